/* project.f */
hdl/mem_map_pkg.sv
hdl/instr_port.sv
hdl/data_port.sv
hdl/dram_sequencer.sv
hdl/mem_map_top.sv
tests/dram_model.sv
tests/tb_mem_map.sv

/* Makefile */
# Verilator build for the memory-map unit.

VERILATOR    ?= verilator
TOP          ?= tb_mem_map
RTL_TOP      ?= mem_map_top
FILELIST     ?= project.f
OBJ_DIR      ?= obj_dir
LOG          ?= sim.log
WAVES        ?= 0
SEED_TIMEOUT ?= 120

VFLAGS ?= --timing --assert -f $(FILELIST)

ifeq ($(WAVES),1)
VFLAGS += --trace
endif

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing hdl/mem_map_pkg.sv hdl/instr_port.sv \
		hdl/data_port.sv hdl/dram_sequencer.sv hdl/mem_map_top.sv --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-timeout $(SEED_TIMEOUT) ./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/tb_mem_map.sv */
`timescale 1ns/100ps

module tb_mem_map;

    localparam int lat       = mem_map_pkg::default_dram_latency;
    localparam int ack_bound = 2 * lat + 10;
    localparam int txn_count = 40 + 10 + 20 + 1 + 4 + 17;
    localparam int wd_cycles = txn_count * (2 * lat + 10) + 64;

    logic clk;
    logic rst;
    logic i_cyc, i_stb, i_ack;
    logic d_cyc, d_stb, d_we, d_ack;
    logic dram_write_en;
    mem_map_pkg::word_t      i_addr, i_data, d_addr, d_wdata, d_rdata;
    mem_map_pkg::word_t      dram_write_data, dram_read_data;
    mem_map_pkg::dram_addr_t dram_addr;

    mem_map_pkg::word_t      ref_mem [65536];
    logic [31:0]             rand_state = 32'd14;
    int                      we_count = 0;
    mem_map_pkg::dram_addr_t we_addr;  // address of the last dram write.
    mem_map_pkg::word_t      we_data;

    mem_map_top #(.dram_latency(lat)) u_dut (.*);

    dram_model #(.latency(lat)) u_dram (
        .clk(clk), .dram_addr(dram_addr), .dram_write_en(dram_write_en),
        .dram_write_data(dram_write_data), .dram_read_data(dram_read_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (dram_write_en === 1'b1) begin
            we_count <= we_count + 1;
            we_addr  <= dram_addr;
            we_data  <= dram_write_data;
        end
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: the tests did not finish in %0d cycles", wd_cycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    function logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state >> 8;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input mem_map_pkg::word_t got,
                              input mem_map_pkg::word_t exp);
        if (got !== exp) begin
            $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
            stop_run("word check failed");
        end
    endtask

    task automatic check_dram_addr(input string name, input mem_map_pkg::dram_addr_t got,
                                   input mem_map_pkg::dram_addr_t exp);
        if (got !== exp) begin
            $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
            stop_run("dram address check failed");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
            stop_run("signal level check failed");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
            stop_run("cycle count check failed");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////////////////////////

    task automatic wb_fetch(input mem_map_pkg::word_t addr, output mem_map_pkg::word_t data,
                            output int cycles);
        @(negedge clk);
        i_cyc  = 1'b1;
        i_stb  = 1'b1;
        i_addr = addr;
        @(negedge clk);
        cycles = 1;  // posedges since stb.
        while (!i_ack) begin
            if (cycles >= ack_bound) begin
                stop_run("fetch bus ack did not arrive in time");
            end
            @(negedge clk);
            cycles++;
        end
        data = i_data;
        @(negedge clk);  // strobe held through the ack edge.
        i_cyc = 1'b0;
        i_stb = 1'b0;
    endtask

    task automatic wb_data(input logic we, input mem_map_pkg::word_t addr,
                           input mem_map_pkg::word_t wdata,
                           output mem_map_pkg::word_t rdata, output int cycles);
        @(negedge clk);
        d_cyc   = 1'b1;
        d_stb   = 1'b1;
        d_we    = we;
        d_addr  = addr;
        d_wdata = wdata;
        @(negedge clk);
        cycles = 1;
        while (!d_ack) begin
            if (cycles >= ack_bound) begin
                stop_run("data bus ack did not arrive in time");
            end
            @(negedge clk);
            cycles++;
        end
        rdata = d_rdata;
        @(negedge clk);
        d_cyc = 1'b0;
        d_stb = 1'b0;
        d_we  = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic dram_round_trip();
        mem_map_pkg::word_t addrs [20];
        mem_map_pkg::word_t wd;
        mem_map_pkg::word_t rd;
        int                 cyc;
        for (int i = 0; i < 20; i++) begin
            addrs[i] = mem_map_pkg::word_t'(next_rand() % 32'hF800);
            wd = mem_map_pkg::word_t'(next_rand());
            wb_data(1'b1, addrs[i], wd, rd, cyc);
            ref_mem[addrs[i]] = wd;
            check_count("dram write ack cycles", cyc, lat + 3);
            check_count("dram_write_en pulses", we_count, i + 1);
            check_dram_addr("dram_addr at write", we_addr, {9'd0, addrs[i]});
            check_word("dram_write_data", we_data, wd);
        end
        for (int i = 0; i < 20; i++) begin
            wb_data(1'b0, addrs[i], '0, rd, cyc);
            check_word("d_rdata", rd, ref_mem[addrs[i]]);
            check_count("dram read ack cycles", cyc, lat + 3);
        end
    endtask

    task automatic fetch_from_dram();
        mem_map_pkg::word_t a;
        mem_map_pkg::word_t w;
        mem_map_pkg::word_t rd;
        int                 cyc;
        for (int i = 0; i < 10; i++) begin
            a = mem_map_pkg::word_t'(next_rand() % 32'hF800);
            w = mem_map_pkg::word_t'(next_rand());
            u_dram.mem[a] = w;
            wb_fetch(a, rd, cyc);
            check_word("i_data", rd, w);
            check_dram_addr("dram_addr", dram_addr, {9'd0, a});  // still held after ack.
            check_count("fetch ack cycles", cyc, lat + 3);
        end
    endtask

    task automatic io_and_unmapped();
        mem_map_pkg::word_t rd;
        int                 cyc;
        int                 we_before;
        we_before = we_count;
        for (int i = 0; i < 8; i++) begin
            wb_data(1'b1, 16'hF800 + 16'(i), 16'h1100 + 16'(i * 7), rd, cyc);
            check_count("io write ack cycles", cyc, 1);
        end
        for (int i = 0; i < 8; i++) begin
            wb_data(1'b0, 16'hF800 + 16'(i), '0, rd, cyc);
            check_word("io d_rdata", rd, 16'h1100 + 16'(i * 7));
            check_count("io read ack cycles", cyc, 1);
        end
        wb_data(1'b0, 16'hF900, '0, rd, cyc);
        check_word("unmapped d_rdata", rd, '0);
        wb_data(1'b1, 16'hF900, 16'hBEEF, rd, cyc);
        wb_data(1'b0, 16'hF900, '0, rd, cyc);
        check_word("unmapped d_rdata after write", rd, '0);
        wb_data(1'b0, 16'hF800, '0, rd, cyc);
        check_word("io d_rdata after unmapped write", rd, 16'h1100);
        check_count("dram_write_en pulses", we_count, we_before);
    endtask

    task automatic out_of_map_fetch();
        mem_map_pkg::dram_addr_t addr_before;
        mem_map_pkg::word_t      rd;
        int                      cyc;
        addr_before = dram_addr;
        wb_fetch(16'hFA00, rd, cyc);
        check_word("i_data", rd, '0);
        check_count("out of map fetch ack cycles", cyc, 1);
        check_dram_addr("dram_addr", dram_addr, addr_before);
    endtask

    task automatic contention();
        mem_map_pkg::word_t fa, da, frd, drd;
        int                 fcyc, dcyc, iocyc;
        fa = 16'h0100 + 16'(next_rand() % 256);
        da = 16'h8000 + 16'(next_rand() % 256);
        u_dram.mem[fa] = 16'h5A01;
        u_dram.mem[da] = 16'hC3D2;
        fork
            wb_fetch(fa, frd, fcyc);
            wb_data(1'b0, da, '0, drd, dcyc);
        join
        check_word("i_data", frd, 16'h5A01);
        check_word("d_rdata", drd, 16'hC3D2);
        if (fcyc >= dcyc) begin
            stop_run("fetch did not complete before the data read");
        end
        fork
            wb_fetch(fa, frd, fcyc);
            begin
                repeat (2) @(negedge clk);
                wb_data(1'b1, 16'hF803, 16'h7777, drd, iocyc);
            end
        join
        check_count("io ack cycles during fetch", iocyc, 1);
        check_word("i_data", frd, 16'h5A01);
    endtask

    task automatic reset_state();
        mem_map_pkg::word_t rd;
        int                 cyc;
        for (int i = 0; i < 8; i++) begin
            wb_data(1'b1, 16'hF800 + 16'(i), 16'hFFF0 + 16'(i), rd, cyc);
        end
        // both buses keep dram traffic up while reset is held.
        @(negedge clk);
        rst     = 1'b0;
        i_cyc   = 1'b1;
        i_stb   = 1'b1;
        i_addr  = 16'h0040;
        d_cyc   = 1'b1;
        d_stb   = 1'b1;
        d_we    = 1'b1;
        d_addr  = 16'h0080;
        d_wdata = 16'h1234;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_bit("i_ack", i_ack, 1'b0);
            check_bit("d_ack", d_ack, 1'b0);
            check_bit("dram_write_en", dram_write_en, 1'b0);
        end
        i_cyc = 1'b0;
        i_stb = 1'b0;
        d_cyc = 1'b0;
        d_stb = 1'b0;
        d_we  = 1'b0;
        rst   = 1'b1;
        for (int i = 0; i < 8; i++) begin
            wb_data(1'b0, 16'hF800 + 16'(i), '0, rd, cyc);
            check_word("io d_rdata after reset", rd, '0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst     = 1'b0;
        i_cyc   = 1'b0;
        i_stb   = 1'b0;
        i_addr  = '0;
        d_cyc   = 1'b0;
        d_stb   = 1'b0;
        d_we    = 1'b0;
        d_addr  = '0;
        d_wdata = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        check_bit("i_ack", i_ack, 1'b0);
        check_bit("d_ack", d_ack, 1'b0);
        check_bit("dram_write_en", dram_write_en, 1'b0);
        dram_round_trip();
        fetch_from_dram();
        io_and_unmapped();
        out_of_map_fetch();
        contention();
        reset_state();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* tests/dram_model.sv */
`timescale 1ns/100ps

module dram_model #(
    parameter int latency = mem_map_pkg::default_dram_latency
) (
    input  logic                    clk,
    input  mem_map_pkg::dram_addr_t dram_addr,
    input  logic                    dram_write_en,
    input  mem_map_pkg::word_t      dram_write_data,
    output mem_map_pkg::word_t      dram_read_data
);

    mem_map_pkg::word_t      mem [65536];
    mem_map_pkg::dram_addr_t last_addr;
    int                      age;  // edges since dram_addr last changed.

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = mem_map_pkg::word_t'(i) ^ 16'hA5C3;
        end
        last_addr      = '0;
        age            = 0;
        dram_read_data <= 'x;
    end

    always @(posedge clk) begin
        if (dram_write_en === 1'b1) begin
            mem[dram_addr[15:0]] = dram_write_data;
        end
        if (dram_addr !== last_addr) begin
            last_addr = dram_addr;
            age       = 1;
        end else if (age < latency) begin
            age = age + 1;
        end
        if (age >= latency - 1) begin
            dram_read_data <= mem[dram_addr[15:0]];
        end else begin
            dram_read_data <= 'x;  // data not settled yet.
        end
    end

endmodule

/* hdl/mem_map_top.sv */
`timescale 1ns/100ps

module mem_map_top #(
    parameter int dram_latency = mem_map_pkg::default_dram_latency
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_cyc,
    input  logic                    i_stb,
    input  mem_map_pkg::word_t      i_addr,
    output logic                    i_ack,
    output mem_map_pkg::word_t      i_data,
    input  logic                    d_cyc,
    input  logic                    d_stb,
    input  logic                    d_we,
    input  mem_map_pkg::word_t      d_addr,
    input  mem_map_pkg::word_t      d_wdata,
    output logic                    d_ack,
    output mem_map_pkg::word_t      d_rdata,
    output mem_map_pkg::dram_addr_t dram_addr,
    output logic                    dram_write_en,
    output mem_map_pkg::word_t      dram_write_data,
    input  mem_map_pkg::word_t      dram_read_data
);

    logic                    ireq;
    mem_map_pkg::dram_addr_t ireq_addr;
    logic                    ireq_done;
    logic                    dreq;
    mem_map_pkg::dram_addr_t dreq_addr;
    logic                    dreq_we;
    mem_map_pkg::word_t      dreq_wdata;
    logic                    dreq_done;
    mem_map_pkg::word_t      rdata;  // shared by both sides.

    instr_port u_instr (
        .clk(clk), .rst(rst),
        .i_cyc(i_cyc), .i_stb(i_stb), .i_addr(i_addr),
        .i_ack(i_ack), .i_data(i_data),
        .ireq(ireq), .ireq_addr(ireq_addr),
        .ireq_done(ireq_done), .rdata(rdata)
    );

    data_port u_data (
        .clk(clk), .rst(rst),
        .d_cyc(d_cyc), .d_stb(d_stb), .d_we(d_we),
        .d_addr(d_addr), .d_wdata(d_wdata),
        .d_ack(d_ack), .d_rdata(d_rdata),
        .dreq(dreq), .dreq_addr(dreq_addr), .dreq_we(dreq_we), .dreq_wdata(dreq_wdata),
        .dreq_done(dreq_done), .rdata(rdata)
    );

    dram_sequencer #(.dram_latency(dram_latency)) u_seq (
        .clk(clk), .rst(rst),
        .ireq(ireq), .ireq_addr(ireq_addr), .ireq_done(ireq_done),
        .dreq(dreq), .dreq_addr(dreq_addr), .dreq_we(dreq_we), .dreq_wdata(dreq_wdata),
        .dreq_done(dreq_done),
        .rdata(rdata),
        .dram_addr(dram_addr), .dram_write_en(dram_write_en),
        .dram_write_data(dram_write_data), .dram_read_data(dram_read_data)
    );

endmodule

/* hdl/dram_sequencer.sv */
`timescale 1ns/100ps

module dram_sequencer #(
    parameter int dram_latency = mem_map_pkg::default_dram_latency
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ireq,
    input  mem_map_pkg::dram_addr_t ireq_addr,
    output logic                    ireq_done,
    input  logic                    dreq,
    input  mem_map_pkg::dram_addr_t dreq_addr,
    input  logic                    dreq_we,
    input  mem_map_pkg::word_t      dreq_wdata,
    output logic                    dreq_done,
    output mem_map_pkg::word_t      rdata,
    output mem_map_pkg::dram_addr_t dram_addr,
    output logic                    dram_write_en,
    output mem_map_pkg::word_t      dram_write_data,
    input  mem_map_pkg::word_t      dram_read_data
);

    localparam int cnt_width = $clog2(dram_latency + 1);

    // access spans latency-1 cycles, finish is the last one.
    localparam logic [cnt_width-1:0] cnt_last = cnt_width'(dram_latency - 2);

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_finish
    } state_t;

    state_t               state;
    logic [cnt_width-1:0] count;
    logic                 owner_data;  // 1 when the data side holds the grant.
    logic                 ireq_pending;
    logic                 dreq_pending;
    logic                 grant_fetch;
    logic                 grant_data;

    // a request is still up in its done cycle.
    assign ireq_pending = ireq && !ireq_done;
    assign dreq_pending = dreq && !dreq_done;

    assign grant_fetch = (state == st_idle) && ireq_pending;
    assign grant_data  = (state == st_idle) && !ireq_pending && dreq_pending;

    ////////////////////////////////////////////////////////////
    // fsm and latency counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state         <= st_idle;
            count         <= '0;
            owner_data    <= 1'b0;
            ireq_done     <= 1'b0;
            dreq_done     <= 1'b0;
            dram_write_en <= 1'b0;
        end else begin
            ireq_done     <= 1'b0;
            dreq_done     <= 1'b0;
            dram_write_en <= 1'b0;
            case (state)
                st_idle: begin
                    count <= '0;
                    if (grant_fetch) begin
                        owner_data <= 1'b0;
                        state      <= st_access;
                    end else if (grant_data) begin
                        owner_data    <= 1'b1;
                        dram_write_en <= dreq_we;  // grant cycle only.
                        state         <= st_access;
                    end
                end
                st_access: begin
                    if (count == cnt_last) begin
                        state <= st_finish;
                    end else begin
                        count <= count + cnt_width'(1);
                    end
                end
                st_finish: begin
                    ireq_done <= !owner_data;
                    dreq_done <= owner_data;
                    state     <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant_fetch) begin
            dram_addr <= ireq_addr;
        end else if (grant_data) begin
            dram_addr       <= dreq_addr;
            dram_write_data <= dreq_wdata;
        end
        if (state == st_finish) begin
            rdata <= dram_read_data;
        end
    end

    a_we_grant_only: assert property (@(posedge clk) disable iff (!rst)
        dram_write_en |-> state == st_access && count == '0 && $past(state) == st_idle);

    a_one_done: assert property (@(posedge clk) disable iff (!rst)
        !(ireq_done && dreq_done));

endmodule

/* hdl/data_port.sv */
`timescale 1ns/100ps

module data_port (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    d_cyc,
    input  logic                    d_stb,
    input  logic                    d_we,
    input  mem_map_pkg::word_t      d_addr,
    input  mem_map_pkg::word_t      d_wdata,
    output logic                    d_ack,
    output mem_map_pkg::word_t      d_rdata,
    output logic                    dreq,
    output mem_map_pkg::dram_addr_t dreq_addr,
    output logic                    dreq_we,
    output mem_map_pkg::word_t      dreq_wdata,
    input  logic                    dreq_done,
    input  mem_map_pkg::word_t      rdata
);

    localparam int io_idx_width = $clog2(mem_map_pkg::io_count);

    mem_map_pkg::word_t      io_regs [mem_map_pkg::io_count];
    logic [io_idx_width-1:0] io_idx;
    logic                    busy;
    logic                    accept;
    mem_map_pkg::region_t    region;

    assign accept = d_cyc && d_stb && !busy;
    assign region = mem_map_pkg::region_of(d_addr);
    assign io_idx = d_addr[io_idx_width-1:0];

    ////////////////////////////////////////////////////////////
    // handshake and i/o register bank
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy  <= 1'b0;
            dreq  <= 1'b0;
            d_ack <= 1'b0;
            for (int i = 0; i < mem_map_pkg::io_count; i++) begin
                io_regs[i] <= '0;
            end
        end else begin
            d_ack <= 1'b0;
            if (d_ack) begin
                busy <= 1'b0;
            end
            if (accept) begin
                busy <= 1'b1;
                case (region)
                    mem_map_pkg::region_dram: begin
                        dreq <= 1'b1;
                    end
                    mem_map_pkg::region_io: begin
                        if (d_we) begin
                            io_regs[io_idx] <= d_wdata;
                        end
                        d_ack <= 1'b1;
                    end
                    default: begin
                        d_ack <= 1'b1;  // unmapped, write dropped.
                    end
                endcase
            end
            if (dreq_done) begin
                dreq  <= 1'b0;
                d_ack <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // request fields and read data
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            dreq_addr  <= mem_map_pkg::dram_addr_t'(d_addr);
            dreq_we    <= d_we;
            dreq_wdata <= d_wdata;
            if (!d_we) begin
                if (region == mem_map_pkg::region_io) begin
                    d_rdata <= io_regs[io_idx];
                end else if (region == mem_map_pkg::region_none) begin
                    d_rdata <= '0;
                end
            end
        end
        if (dreq_done && !dreq_we) begin
            d_rdata <= rdata;  // dram writes keep old value.
        end
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst)
        $rose(d_ack) |-> $past(d_cyc && d_stb) && d_cyc && d_stb);

endmodule

/* hdl/instr_port.sv */
`timescale 1ns/100ps

module instr_port (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_cyc,
    input  logic                    i_stb,
    input  mem_map_pkg::word_t      i_addr,
    output logic                    i_ack,
    output mem_map_pkg::word_t      i_data,
    output logic                    ireq,
    output mem_map_pkg::dram_addr_t ireq_addr,
    input  logic                    ireq_done,
    input  mem_map_pkg::word_t      rdata
);

    logic                 busy;  // set on accept, cleared after the ack cycle.
    logic                 accept;
    mem_map_pkg::region_t region;

    assign accept = i_cyc && i_stb && !busy;
    assign region = mem_map_pkg::region_of(i_addr);

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy  <= 1'b0;
            ireq  <= 1'b0;
            i_ack <= 1'b0;
        end else begin
            i_ack <= 1'b0;
            if (i_ack) begin
                busy <= 1'b0;
            end
            if (accept) begin
                busy <= 1'b1;
                if (region == mem_map_pkg::region_dram) begin
                    ireq <= 1'b1;
                end else begin
                    i_ack <= 1'b1;  // out of map, no dram access.
                end
            end
            if (ireq_done) begin
                ireq  <= 1'b0;
                i_ack <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ireq_addr <= mem_map_pkg::dram_addr_t'(i_addr);
            if (region != mem_map_pkg::region_dram) begin
                i_data <= '0;  // zero instruction word.
            end
        end
        if (ireq_done) begin
            i_data <= rdata;
        end
    end

    // the master keeps the strobe up until it sees ack.
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst)
        $rose(i_ack) |-> $past(i_cyc && i_stb) && i_cyc && i_stb);

endmodule

/* hdl/mem_map_pkg.sv */
package mem_map_pkg;

    ////////////////////////////////////////////////////////////
    // widths and types
    ////////////////////////////////////////////////////////////

    localparam int word_width      = 16;
    localparam int dram_addr_width = 25;

    typedef logic [word_width-1:0]      word_t;
    typedef logic [dram_addr_width-1:0] dram_addr_t;

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////

    localparam word_t dram_last = 16'hF7FF;  // dram starts at zero.
    localparam word_t io_base   = 16'hF800;
    localparam int    io_count  = 8;

    typedef enum logic [1:0] {
        region_dram,
        region_io,
        region_none
    } region_t;

    // decode a cpu address into its region.
    function automatic region_t region_of(input word_t addr);
        if (addr <= dram_last) begin
            return region_dram;
        end
        if (addr >= io_base && addr < io_base + word_t'(io_count)) begin
            return region_io;
        end
        return region_none;
    endfunction

    // cycles from address to valid read data.
    localparam int default_dram_latency = 12;

endpackage
